/* design/mlpPkg.sv */
package mlpPkg;

	typedef logic [15:0] wordT;  // two's complement activation or weight

	localparam int NumInputs = 15;
	localparam int NumHidden = 6;
	localparam int NumOutputs = 4;

	typedef wordT [NumInputs-1:0] inputVecT;
	typedef wordT [NumHidden-1:0] hiddenVecT;
	typedef wordT [NumOutputs-1:0] outputVecT;

	// tag is chosen by the sender and comes back with the result
	typedef struct packed
	{
		wordT tag;
		inputVecT data;
	} sampleT;

	typedef struct packed
	{
		wordT tag;
		outputVecT data;
	} resultT;

	// one row per hidden neuron, one column per input word
	localparam wordT [0:NumHidden-1][0:NumInputs-1] HiddenWeights = '{
		'{ 12,  -7,  25,   3, -19,  40,  -2,   8, -33,  17,   5, -11,  29,  -4,  21},
		'{-28,  14,   6, -40,   9,   2,  31, -15,  22,  -6, -37,  18,   1,  26,  -9},
		'{  7,  33, -21,  11,  -3, -26,  15,  39, -12,   4,  20, -30,  -8,  13,  36},
		'{-17,  -5,  42,  24, -14,  10, -35,   0,  19, -23,  16,  27, -41,   5,  -1},
		'{ 30, -20,  -9,   1,  34, -13,  23, -27,   8,  38, -16,  -2,  11, -31,   6},
		'{-36,  29,  37,  14,  12, -18,   6,  35,  -6,  16, -15,   3,   7, -42, -11}
	};

	localparam wordT [0:NumHidden-1] HiddenBias = '{
		1,
		-3,
		4,
		0,
		-2,
		1
	};

	// one row per output neuron, one column per hidden word
	localparam wordT [0:NumOutputs-1][0:NumHidden-1] OutputWeights = '{
		'{  9, -14,  22,  -5,  17, -30},
		'{-12,  26,   3,  19,  -8,  11},
		'{ 35,  -2, -18,   7,  28, -24},
		'{ -4,  13,  31, -39,   2,  15}
	};

	localparam wordT [0:NumOutputs-1] OutputBias = '{
		-2,
		5,
		0,
		3
	};

endpackage

/* design/neuron.sv */
`timescale 1ns/1ps

module neuron #(
	parameter int NumIn = 1,
	parameter mlpPkg::wordT [0:NumIn-1] Weights = '0,
	parameter mlpPkg::wordT Bias = '0
)
(
	input logic clk,
	input logic reset,
	input mlpPkg::wordT [NumIn-1:0] activations,
	output mlpPkg::wordT result
);

	mlpPkg::wordT [NumIn-1:0] actReg;  // edge 1
	mlpPkg::wordT [NumIn-1:0] products;
	mlpPkg::wordT weightedSum;
	mlpPkg::wordT sumReg;  // edge 2

	// low 16 bits of each product only
	always_comb
	begin
		for (int i = 0; i < NumIn; i++)
		begin
			products[i] = mlpPkg::wordT'(actReg[i] * Weights[i]);
		end
	end

	always_comb
	begin
		weightedSum = Bias;
		for (int i = 0; i < NumIn; i++)
		begin
			weightedSum = weightedSum + products[i];  // wraps at 16 bits
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			actReg <= '0;
			sumReg <= '0;
			result <= '0;
		end
		else
		begin
			actReg <= activations;
			sumReg <= weightedSum;
			if (sumReg[15])
			begin
				result <= '0;  // relu clamps negatives to zero
			end
			else
			begin
				result <= sumReg;
			end
		end
	end

endmodule

/* design/denseLayer.sv */
`timescale 1ns/1ps

module denseLayer #(
	parameter int NumIn = 1,
	parameter int NumOut = 1,
	parameter mlpPkg::wordT [0:NumOut-1][0:NumIn-1] Weights = '0,
	parameter mlpPkg::wordT [0:NumOut-1] Biases = '0
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpPkg::wordT inTag,
	input mlpPkg::wordT [NumIn-1:0] activations,
	output logic outValid,
	output mlpPkg::wordT outTag,
	output mlpPkg::wordT [NumOut-1:0] outputs
);

	// matches the three register stages inside each neuron
	logic [2:0] validPipe;
	mlpPkg::wordT [2:0] tagPipe;

	genvar n;
	generate
		for (n = 0; n < NumOut; n++)
		begin : genNeuron
			neuron #(
				.NumIn(NumIn),
				.Weights(Weights[n]),
				.Bias(Biases[n])
			) i_neuron (
				.clk(clk),
				.reset(reset),
				.activations(activations),
				.result(outputs[n])
			);
		end
	endgenerate

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			validPipe <= '0;
			tagPipe <= '0;
		end
		else
		begin
			validPipe <= {validPipe[1:0], inValid};
			tagPipe <= {tagPipe[1:0], inTag};  // tag rides beside valid
		end
	end

	assign outValid = validPipe[2];
	assign outTag = tagPipe[2];

endmodule

/* design/resultFifo.sv */
`timescale 1ns/1ps

module resultFifo #(
	parameter int Depth = 4
)
(
	input logic clk,
	input logic reset,
	input logic push,
	input mlpPkg::resultT pushEntry,
	input logic pop,
	output mlpPkg::resultT headEntry,
	output logic empty
);

	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CountWidth = $clog2(Depth + 1);

	mlpPkg::resultT entries [Depth];  // no reset on storage
	logic [PtrWidth-1:0] readPtr;
	logic [PtrWidth-1:0] writePtr;
	logic [CountWidth-1:0] count;
	logic full;

	// wraps at any depth and not only at powers of two
	function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
		if (ptr == PtrWidth'(Depth - 1))
		begin
			return '0;
		end
		return ptr + 1'b1;
	endfunction

	always_ff @(posedge clk)
	begin
		if (push)
		begin
			entries[writePtr] <= pushEntry;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			readPtr <= '0;
			writePtr <= '0;
			count <= '0;
		end
		else
		begin
			if (push)
			begin
				writePtr <= nextPtr(writePtr);
			end
			if (pop)
			begin
				readPtr <= nextPtr(readPtr);
			end
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;  // both or neither
			endcase
		end
	end

	assign empty = (count == '0);
	assign full = (count == CountWidth'(Depth));
	assign headEntry = entries[readPtr];  // visible the cycle after the write

	// upstream credit must keep the pipeline from overrunning the buffer
	noPushWhenFull: assert property (@(posedge clk) disable iff (reset) !(push && full));
	noPopWhenEmpty: assert property (@(posedge clk) disable iff (reset) !(pop && empty));

endmodule

/* design/creditCounter.sv */
`timescale 1ns/1ps

module creditCounter #(
	parameter int MaxCredits = 7
)
(
	input logic clk,
	input logic reset,
	input logic creditIn,
	input logic empty,
	output logic sendGrant
);

	localparam int CountWidth = $clog2(MaxCredits + 1);

	logic [CountWidth-1:0] creditCount;

	// one send per credit and only with a result waiting
	assign sendGrant = (creditCount != '0) && !empty;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			creditCount <= '0;
		end
		else
		begin
			case ({creditIn, sendGrant})
				2'b10: creditCount <= creditCount + 1'b1;
				2'b01: creditCount <= creditCount - 1'b1;
				default: creditCount <= creditCount;  // grant and send cancel
			endcase
		end
	end

	// downstream must not grant more than MaxCredits ahead
	creditBound: assert property (@(posedge clk) disable iff (reset)
		!(creditIn && !sendGrant && creditCount == CountWidth'(MaxCredits)));

endmodule

/* design/mlpCore.sv */
`timescale 1ns/1ps

module mlpCore #(
	parameter int FifoDepth = 4,
	parameter int MaxCredits = 7
)
(
	input logic clk,
	input logic reset,
	input logic inValid,
	input mlpPkg::sampleT inSample,
	output logic inCreditReturn,
	input logic outCredit,
	output logic outValid,
	output mlpPkg::resultT outResult
);

	logic hiddenValid;
	mlpPkg::wordT hiddenTag;
	mlpPkg::hiddenVecT hiddenVec;
	logic resultValid;
	mlpPkg::wordT resultTag;
	mlpPkg::outputVecT resultVec;
	mlpPkg::resultT fifoEntry;
	logic fifoEmpty;
	logic sendGrant;

	denseLayer #(
		.NumIn(mlpPkg::NumInputs),
		.NumOut(mlpPkg::NumHidden),
		.Weights(mlpPkg::HiddenWeights),
		.Biases(mlpPkg::HiddenBias)
	) i_hiddenLayer (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inTag(inSample.tag),
		.activations(inSample.data),
		.outValid(hiddenValid),
		.outTag(hiddenTag),
		.outputs(hiddenVec)
	);

	denseLayer #(
		.NumIn(mlpPkg::NumHidden),
		.NumOut(mlpPkg::NumOutputs),
		.Weights(mlpPkg::OutputWeights),
		.Biases(mlpPkg::OutputBias)
	) i_outputLayer (
		.clk(clk),
		.reset(reset),
		.inValid(hiddenValid),
		.inTag(hiddenTag),
		.activations(hiddenVec),
		.outValid(resultValid),
		.outTag(resultTag),
		.outputs(resultVec)
	);

	assign fifoEntry = '{tag: resultTag, data: resultVec};

	// upstream credits size the buffer so the pipeline never stalls
	resultFifo #(
		.Depth(FifoDepth)
	) i_resultFifo (
		.clk(clk),
		.reset(reset),
		.push(resultValid),
		.pushEntry(fifoEntry),
		.pop(sendGrant),
		.headEntry(outResult),
		.empty(fifoEmpty)
	);

	creditCounter #(
		.MaxCredits(MaxCredits)
	) i_creditCounter (
		.clk(clk),
		.reset(reset),
		.creditIn(outCredit),
		.empty(fifoEmpty),
		.sendGrant(sendGrant)
	);

	assign outValid = sendGrant;
	assign inCreditReturn = sendGrant;  // a slot frees as each result leaves

endmodule

/* verification/mlpTb.sv */
`timescale 1ns/1ps

module mlpTb;

	localparam int FifoDepth = 4;  // DUT defaults
	localparam int MaxCredits = 7;
	localparam int NumSamples = 300;
	localparam int CycleLimit = NumSamples * 20 + 200;
	localparam int ModeOff = 0;
	localparam int ModeRandom = 1;
	localparam int ModeAlways = 2;

	logic clk;
	logic reset;
	logic inValid;
	mlpPkg::sampleT inSample;
	logic inCreditReturn;
	logic outCredit;
	logic outValid;
	mlpPkg::resultT outResult;

	logic [15:0] lfsrState = 16'd38482;
	mlpPkg::resultT expected [$];  // model results in send order
	int cycleCount = 0;
	int upCredits = FifoDepth;
	int dutCredits = 0;  // count inside the DUT for the current cycle
	int sentCount = 0;
	int zeroCount = 0;
	int sendCycle = 0;
	int lastOutCycle = 0;

	mlpCore i_mlpCore (
		.clk(clk),
		.reset(reset),
		.inValid(inValid),
		.inSample(inSample),
		.inCreditReturn(inCreditReturn),
		.outCredit(outCredit),
		.outValid(outValid),
		.outResult(outResult)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic checkEqual(input logic [63:0] got, input logic [63:0] want, input string msg);
		if (got !== want)
		begin
			$display("Mismatch at %0t: %s, got %0h expected %0h", $time, msg, got, want);
			$display("ERRORS FOUND");
			$fatal(1, "stopped at first failure");
		end
	endtask

	// x^16 + x^14 + x^13 + x^11
	function automatic logic nextBit();
		lfsrState = {lfsrState[14:0], lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10]};
		return lfsrState[0];
	endfunction

	function automatic mlpPkg::wordT randomWord();
		mlpPkg::wordT w;
		w = '0;
		for (int b = 0; b < 16; b++)
		begin
			w = {w[14:0], nextBit()};
		end
		return w;
	endfunction

	// both layers with 16-bit wrapping products and sums and relu on bit 15
	function automatic mlpPkg::resultT modelResult(input mlpPkg::sampleT s);
		mlpPkg::hiddenVecT hidden;
		mlpPkg::outputVecT outs;
		mlpPkg::wordT acc;
		mlpPkg::wordT prod;
		mlpPkg::resultT r;
		for (int n = 0; n < mlpPkg::NumHidden; n++)
		begin
			acc = mlpPkg::HiddenBias[n];
			for (int i = 0; i < mlpPkg::NumInputs; i++)
			begin
				prod = s.data[i] * mlpPkg::HiddenWeights[n][i];
				acc = acc + prod;
			end
			hidden[n] = acc[15] ? '0 : acc;
		end
		for (int n = 0; n < mlpPkg::NumOutputs; n++)
		begin
			acc = mlpPkg::OutputBias[n];
			for (int i = 0; i < mlpPkg::NumHidden; i++)
			begin
				prod = hidden[i] * mlpPkg::OutputWeights[n][i];
				acc = acc + prod;
			end
			outs[n] = acc[15] ? '0 : acc;
		end
		r.tag = s.tag;
		r.data = outs;
		return r;
	endfunction

	// runs at the falling edge, where outputs have settled
	task automatic sampleOutputs();
		mlpPkg::resultT got;
		mlpPkg::resultT want;
		got = outResult;
		checkEqual(64'(inCreditReturn), 64'(outValid), "inCreditReturn differs from outValid");
		if (outValid)
		begin
			if (dutCredits == 0)
			begin
				abortRun("outValid was raised without an unused downstream credit");
			end
			if (expected.size() == 0)
			begin
				abortRun("outValid was raised while no result was expected");
			end
			want = expected.pop_front();
			checkEqual(64'(got.tag), 64'(want.tag), "result tag");
			checkEqual(64'(got.data), 64'(want.data), "result words");
			for (int k = 0; k < mlpPkg::NumOutputs; k++)
			begin
				if (got.data[k] == '0)
				begin
					zeroCount++;
				end
			end
			lastOutCycle = cycleCount;
		end
		dutCredits = dutCredits + int'(outCredit) - int'(outValid);  // count after next edge
		if (inCreditReturn)
		begin
			upCredits++;
		end
	endtask

	task automatic stepCycle(input int sendMode, input int creditMode);
		logic doSend;
		logic doCredit;
		mlpPkg::sampleT s;
		@(posedge clk);
		cycleCount++;
		if (cycleCount > CycleLimit)
		begin
			abortRun("timeout: the tests did not finish within the cycle limit");
		end
		doSend = 1'b0;
		if (upCredits > 0 && sendMode != ModeOff)
		begin
			doSend = (sendMode == ModeAlways) ? 1'b1 : nextBit();
		end
		if (doSend)
		begin
			s.tag = mlpPkg::wordT'(sentCount);
			for (int i = 0; i < mlpPkg::NumInputs; i++)
			begin
				s.data[i] = randomWord();
			end
			inValid <= 1'b1;
			inSample <= s;
			expected.push_back(modelResult(s));
			upCredits--;
			sentCount++;
			sendCycle = cycleCount;
		end
		else
		begin
			inValid <= 1'b0;
		end
		doCredit = 1'b0;
		if (creditMode != ModeOff && dutCredits < MaxCredits)
		begin
			doCredit = (creditMode == ModeAlways) ? 1'b1 : nextBit();
		end
		outCredit <= doCredit;
		@(negedge clk);
		sampleOutputs();
	endtask

	task automatic applyReset();
		repeat (5)
		begin
			@(posedge clk);
			cycleCount++;
			@(negedge clk);
			checkEqual(64'(outValid), 64'(0), "outValid during reset");
			checkEqual(64'(inCreditReturn), 64'(0), "inCreditReturn during reset");
		end
		@(posedge clk);
		cycleCount++;
		reset <= 1'b0;
		@(negedge clk);
		checkEqual(64'(outValid), 64'(0), "outValid in the cycle after reset");
		checkEqual(64'(inCreditReturn), 64'(0), "inCreditReturn in the cycle after reset");
	endtask

	initial
	begin
		reset = 1'b1;
		inValid = 1'b0;
		inSample = '0;
		outCredit = 1'b0;
		applyReset();

		while (sentCount < NumSamples / 2)
		begin
			stepCycle(ModeRandom, ModeRandom);
		end

		// downstream stalls while upstream sends on its remaining credit
		repeat (60)
		begin
			stepCycle(ModeAlways, ModeOff);
		end
		checkEqual(64'(upCredits), 64'(0), "upstream credit left after back-pressure");
		checkEqual(64'(expected.size()), 64'(FifoDepth), "results held during back-pressure");
		checkEqual(64'(dutCredits), 64'(0), "downstream credit left after back-pressure");

		while (sentCount < NumSamples - 1)
		begin
			stepCycle(ModeRandom, ModeRandom);
		end
		while (expected.size() > 0)
		begin
			stepCycle(ModeOff, ModeAlways);
		end
		repeat (2)
		begin
			stepCycle(ModeOff, ModeAlways);
		end
		if (dutCredits == 0)
		begin
			abortRun("no downstream credit was prepared before the latency test");
		end

		// lone sample into an empty FIFO with credit ready
		stepCycle(ModeAlways, ModeOff);
		while (expected.size() > 0)
		begin
			stepCycle(ModeOff, ModeOff);
		end
		checkEqual(64'(lastOutCycle - sendCycle), 64'(7), "inValid to outValid latency");

		checkEqual(64'(expected.size()), 64'(0), "results still expected at the end");
		if (zeroCount == 0)
		begin
			abortRun("no zero output word was seen among the matched results");
		end
		else
		begin
			$display("NO ERRORS");
			$finish;
		end
	end

endmodule

/* vlog.f */
design/mlpPkg.sv
design/neuron.sv
design/denseLayer.sv
design/resultFifo.sv
design/creditCounter.sv
design/mlpCore.sv
verification/mlpTb.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := mlpTb
FILELIST  := vlog.f
BUILD_DIR := obj_dir
LOG       := sim.log
FAIL_MSG  := ERRORS FOUND
PASS_MSG  := NO ERRORS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	else \
		echo "simulation passed"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
